//--- hdl/dcache_pkg.sv
`default_nettype none

package dcache_pkg;

    // cache geometry
    localparam int DTAG_W = 26;
    localparam int DIDX_W = 3;
    localparam int DBLK_W = 1;
    localparam int DBYT_W = 2;
    localparam int DWAYS  = 2;
    localparam int DSETS  = 8;

    // register block byte offsets
    localparam int CSR_AW = 5;
    localparam logic [CSR_AW-1:0] CSR_CTRL   = 5'h00;
    localparam logic [CSR_AW-1:0] CSR_STATUS = 5'h04;
    localparam logic [CSR_AW-1:0] CSR_HITS   = 5'h08;
    localparam logic [CSR_AW-1:0] CSR_MISSES = 5'h0C;
    localparam logic [CSR_AW-1:0] CSR_WBACKS = 5'h10;

    typedef logic [31:0] word_t;

    typedef struct packed {
        logic [DTAG_W-1:0] tag;
        logic [DIDX_W-1:0] idx;
        logic [DBLK_W-1:0] blkoff;
        logic [DBYT_W-1:0] bytoff;
    } dcache_addr_t;

    // one way of one set, 92 bits
    typedef struct packed {
        logic              valid;
        logic              dirty;
        logic [DTAG_W-1:0] tag;
        word_t [1:0]       data;
    } dcache_frame_t;

    typedef struct packed {
        logic         ren;
        logic         wen;
        dcache_addr_t addr;
        word_t        store;
    } cpu_req_t;

    typedef struct packed {
        logic  ren;
        logic  wen;
        word_t addr;
        word_t store;
    } mem_req_t;

    // single-cycle pulses from the controller
    typedef struct packed {
        logic hit;
        logic miss;
        logic writeback;
    } cache_event_t;

    typedef struct packed {
        logic              cyc;
        logic              stb;
        logic              we;
        logic [CSR_AW-1:0] adr;
        word_t             dat_w;
    } wb_req_t;

    typedef struct packed {
        logic  ack;
        word_t dat_r;
    } wb_rsp_t;

endpackage

`default_nettype wire

//--- hdl/dcache_frames.sv
`default_nettype none
`timescale 1ns/100ps

module dcache_frames (
    input  logic                                              CLK,
    input  logic                                              nRST,
    input  logic [dcache_pkg::DIDX_W-1:0]                     rd_idx,
    output dcache_pkg::dcache_frame_t [dcache_pkg::DWAYS-1:0] rd_frames,
    input  logic                                              wr_en,
    input  logic                                              wr_way,
    input  logic [dcache_pkg::DIDX_W-1:0]                     wr_idx,
    input  dcache_pkg::dcache_frame_t                         wr_frame,
    input  logic                                              lru_touch,
    input  logic                                              lru_way,
    output logic                                              lru_victim
);
    import dcache_pkg::*;

    // status bits per way and set
    logic [DWAYS-1:0][DSETS-1:0] valid_q;
    logic [DWAYS-1:0][DSETS-1:0] dirty_q;

    // tag and block storage
    logic [DTAG_W-1:0] tag_q  [DWAYS][DSETS];
    word_t [1:0]       data_q [DWAYS][DSETS];

    // one bit per set naming the way to evict next
    logic [DSETS-1:0] lru_q;

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            valid_q <= '0;
            dirty_q <= '0;
            lru_q   <= '0;
        end else begin
            if (wr_en) begin
                valid_q[wr_way][wr_idx] <= wr_frame.valid;
                dirty_q[wr_way][wr_idx] <= wr_frame.dirty;
            end
            // touched way becomes MRU, the other one is the victim
            if (lru_touch) begin
                lru_q[rd_idx] <= ~lru_way;
            end
        end
    end

    always_ff @(posedge CLK) begin
        if (wr_en) begin
            tag_q[wr_way][wr_idx]  <= wr_frame.tag;
            data_q[wr_way][wr_idx] <= wr_frame.data;
        end
    end

    // both ways of the indexed set, read combinationally
    always_comb begin
        for (int w = 0; w < DWAYS; w++) begin
            rd_frames[w].valid = valid_q[w][rd_idx];
            rd_frames[w].dirty = dirty_q[w][rd_idx];
            rd_frames[w].tag   = tag_q[w][rd_idx];
            rd_frames[w].data  = data_q[w][rd_idx];
        end
    end

    assign lru_victim = lru_q[rd_idx];

endmodule

`default_nettype wire

//--- hdl/dcache_ctrl.sv
`default_nettype none
`timescale 1ns/100ps

module dcache_ctrl (
    input  logic                                              CLK,
    input  logic                                              nRST,
    input  dcache_pkg::cpu_req_t                              cpu_req,
    output logic                                              dhit,
    output dcache_pkg::word_t                                 dmemload,
    output dcache_pkg::mem_req_t                              mem_req,
    input  logic                                              mem_wait,
    input  dcache_pkg::word_t                                 mem_load,
    output logic [dcache_pkg::DIDX_W-1:0]                     rd_idx,
    input  dcache_pkg::dcache_frame_t [dcache_pkg::DWAYS-1:0] rd_frames,
    input  logic                                              lru_victim,
    output logic                                              wr_en,
    output logic                                              wr_way,
    output logic [dcache_pkg::DIDX_W-1:0]                     wr_idx,
    output dcache_pkg::dcache_frame_t                         wr_frame,
    output logic                                              lru_touch,
    output logic                                              lru_way,
    output dcache_pkg::cache_event_t                          events,
    input  logic                                              flush_req,
    output logic                                              flush_done
);
    import dcache_pkg::*;

    typedef enum logic [2:0] {
        COMPARE,
        WB0,
        WB1,
        FILL0,
        FILL1,
        FLUSH_SCAN,
        FLUSH_WB0,
        FLUSH_WB1
    } state_t;

    state_t state, next_state;

    // flush position, top bit marks the end of the scan
    logic [DIDX_W+1:0] flush_cnt, next_flush_cnt;
    logic              victim_q, next_victim;
    logic              refill_q, next_refill;
    word_t             fill_lo;

    logic              in_flush;
    logic [DIDX_W-1:0] flush_idx;
    logic              flush_way;
    logic              access;
    logic [DWAYS-1:0]  hit_vec;
    logic              hit;
    logic              hit_way;
    dcache_frame_t     vic_frame;
    dcache_frame_t     flu_frame;

    // byte address of one word of a block
    function automatic word_t blk_addr(input logic [DTAG_W-1:0] tag,
                                       input logic [DIDX_W-1:0] idx,
                                       input logic [DBLK_W-1:0] blk);
        dcache_addr_t a;
        a.tag    = tag;
        a.idx    = idx;
        a.blkoff = blk;
        a.bytoff = '0;
        return a;
    endfunction

    assign in_flush  = state inside {FLUSH_SCAN, FLUSH_WB0, FLUSH_WB1};
    assign flush_idx = flush_cnt[DIDX_W-1:0];
    assign flush_way = flush_cnt[DIDX_W];
    assign rd_idx    = in_flush ? flush_idx : cpu_req.addr.idx;
    assign access    = cpu_req.ren | cpu_req.wen;

    always_comb begin
        for (int w = 0; w < DWAYS; w++) begin
            hit_vec[w] = rd_frames[w].valid && (rd_frames[w].tag == cpu_req.addr.tag);
        end
    end

    assign hit       = |hit_vec;
    assign hit_way   = hit_vec[1];
    assign vic_frame = rd_frames[victim_q];
    assign flu_frame = rd_frames[flush_way];

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            state     <= COMPARE;
            flush_cnt <= '0;
            victim_q  <= 1'b0;
            refill_q  <= 1'b0;
        end else begin
            state     <= next_state;
            flush_cnt <= next_flush_cnt;
            victim_q  <= next_victim;
            refill_q  <= next_refill;
        end
    end

    // first fill word waits here until the second one arrives
    always_ff @(posedge CLK) begin
        if (state == FILL0 && !mem_wait) begin
            fill_lo <= mem_load;
        end
    end

    always_comb begin
        next_state     = state;
        next_flush_cnt = flush_cnt;
        next_victim    = victim_q;
        next_refill    = refill_q;
        dhit           = 1'b0;
        dmemload       = '0;
        mem_req        = '0;
        wr_en          = 1'b0;
        wr_way         = hit_way;
        wr_idx         = cpu_req.addr.idx;
        wr_frame       = rd_frames[hit_way];
        lru_touch      = 1'b0;
        lru_way        = hit_way;
        events         = '0;
        flush_done     = 1'b0;

        case (state)
            COMPARE: begin
                if (flush_req) begin
                    next_state     = FLUSH_SCAN;
                    next_flush_cnt = '0;
                end else if (access && hit) begin
                    dhit        = 1'b1;
                    dmemload    = rd_frames[hit_way].data[cpu_req.addr.blkoff];
                    lru_touch   = 1'b1;
                    // the hit that closes a miss is not counted again
                    events.hit  = !refill_q;
                    next_refill = 1'b0;
                    if (cpu_req.wen) begin
                        dmemload = cpu_req.store;
                        wr_en    = 1'b1;
                        wr_frame.dirty = 1'b1;
                        wr_frame.data[cpu_req.addr.blkoff] = cpu_req.store;
                    end
                end else if (access) begin
                    events.miss = 1'b1;
                    next_victim = lru_victim;
                    next_state  = rd_frames[lru_victim].dirty ? WB0 : FILL0;
                end
            end

            WB0: begin
                mem_req.wen   = 1'b1;
                mem_req.addr  = blk_addr(vic_frame.tag, cpu_req.addr.idx, 1'b0);
                mem_req.store = vic_frame.data[0];
                if (!mem_wait) begin
                    next_state = WB1;
                end
            end

            WB1: begin
                mem_req.wen   = 1'b1;
                mem_req.addr  = blk_addr(vic_frame.tag, cpu_req.addr.idx, 1'b1);
                mem_req.store = vic_frame.data[1];
                if (!mem_wait) begin
                    events.writeback = 1'b1;
                    next_state       = FILL0;
                end
            end

            FILL0: begin
                mem_req.ren  = 1'b1;
                mem_req.addr = blk_addr(cpu_req.addr.tag, cpu_req.addr.idx, 1'b0);
                if (!mem_wait) begin
                    next_state = FILL1;
                end
            end

            FILL1: begin
                mem_req.ren  = 1'b1;
                mem_req.addr = blk_addr(cpu_req.addr.tag, cpu_req.addr.idx, 1'b1);
                if (!mem_wait) begin
                    wr_en            = 1'b1;
                    wr_way           = victim_q;
                    wr_frame.valid   = 1'b1;
                    wr_frame.dirty   = 1'b0;
                    wr_frame.tag     = cpu_req.addr.tag;
                    wr_frame.data[0] = fill_lo;
                    wr_frame.data[1] = mem_load;
                    next_refill      = 1'b1;
                    next_state       = COMPARE;
                end
            end

            FLUSH_SCAN: begin
                if (flush_cnt[DIDX_W+1]) begin
                    flush_done     = 1'b1;
                    next_flush_cnt = '0;
                    next_state     = COMPARE;
                end else if (flu_frame.dirty) begin
                    next_state = FLUSH_WB0;
                end else begin
                    next_flush_cnt = flush_cnt + 1'b1;
                end
            end

            FLUSH_WB0: begin
                mem_req.wen   = 1'b1;
                mem_req.addr  = blk_addr(flu_frame.tag, flush_idx, 1'b0);
                mem_req.store = flu_frame.data[0];
                if (!mem_wait) begin
                    next_state = FLUSH_WB1;
                end
            end

            FLUSH_WB1: begin
                mem_req.wen   = 1'b1;
                mem_req.addr  = blk_addr(flu_frame.tag, flush_idx, 1'b1);
                mem_req.store = flu_frame.data[1];
                if (!mem_wait) begin
                    // block is now clean in memory
                    events.writeback = 1'b1;
                    wr_en            = 1'b1;
                    wr_way           = flush_way;
                    wr_idx           = flush_idx;
                    wr_frame         = flu_frame;
                    wr_frame.dirty   = 1'b0;
                    next_flush_cnt   = flush_cnt + 1'b1;
                    next_state       = FLUSH_SCAN;
                end
            end

            default: begin
                next_state = COMPARE;
            end
        endcase
    end

endmodule

`default_nettype wire

//--- hdl/dcache_csr.sv
`default_nettype none
`timescale 1ns/100ps

module dcache_csr (
    input  logic                     CLK,
    input  logic                     nRST,
    input  dcache_pkg::wb_req_t      wb_req,
    output dcache_pkg::wb_rsp_t      wb_rsp,
    input  dcache_pkg::cache_event_t events,
    input  logic                     flush_done,
    output logic                     flush_req
);
    import dcache_pkg::*;

    logic  ack_q;
    logic  done_q;
    word_t hits_q;
    word_t misses_q;
    word_t wbacks_q;
    word_t rd_data;
    word_t dat_r_q;
    logic  access;
    logic  wr_ctrl;

    // new strobe seen while no ack is pending
    assign access  = wb_req.cyc && wb_req.stb && !ack_q;
    assign wr_ctrl = access && wb_req.we && (wb_req.adr == CSR_CTRL);

    always_comb begin
        case (wb_req.adr)
            CSR_STATUS: rd_data = {30'b0, flush_req, done_q};
            CSR_HITS:   rd_data = hits_q;
            CSR_MISSES: rd_data = misses_q;
            CSR_WBACKS: rd_data = wbacks_q;
            default:    rd_data = '0;
        endcase
    end

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            ack_q     <= 1'b0;
            flush_req <= 1'b0;
            done_q    <= 1'b0;
            hits_q    <= '0;
            misses_q  <= '0;
            wbacks_q  <= '0;
        end else begin
            ack_q <= access;

            if (flush_done) begin
                flush_req <= 1'b0;
                done_q    <= 1'b1;
            end
            // a new flush command wins over a finishing one
            if (wr_ctrl && wb_req.dat_w[0]) begin
                flush_req <= 1'b1;
                done_q    <= 1'b0;
            end

            if (wr_ctrl && wb_req.dat_w[1]) begin
                hits_q   <= '0;
                misses_q <= '0;
                wbacks_q <= '0;
            end else begin
                hits_q   <= hits_q + word_t'(events.hit);
                misses_q <= misses_q + word_t'(events.miss);
                wbacks_q <= wbacks_q + word_t'(events.writeback);
            end
        end
    end

    // read data is captured together with the ack
    always_ff @(posedge CLK) begin
        if (access) begin
            dat_r_q <= rd_data;
        end
    end

    assign wb_rsp.ack   = ack_q;
    assign wb_rsp.dat_r = dat_r_q;

endmodule

`default_nettype wire

//--- hdl/dcache_top.sv
`default_nettype none
`timescale 1ns/100ps

module dcache_top (
    input  logic                 CLK,
    input  logic                 nRST,
    input  dcache_pkg::cpu_req_t cpu_req,
    output logic                 dhit,
    output dcache_pkg::word_t    dmemload,
    output dcache_pkg::mem_req_t mem_req,
    input  logic                 mem_wait,
    input  dcache_pkg::word_t    mem_load,
    input  dcache_pkg::wb_req_t  wb_req,
    output dcache_pkg::wb_rsp_t  wb_rsp
);
    import dcache_pkg::*;

    // frame array read and write ports
    logic [DIDX_W-1:0]               rd_idx;
    dcache_frame_t [DWAYS-1:0]       rd_frames;
    logic                            wr_en;
    logic                            wr_way;
    logic [DIDX_W-1:0]               wr_idx;
    dcache_frame_t                   wr_frame;
    logic                            lru_touch;
    logic                            lru_way;
    logic                            lru_victim;

    // controller to register block
    cache_event_t                    events;
    logic                            flush_req;
    logic                            flush_done;

    dcache_frames u_frames (
        .CLK        (CLK),
        .nRST       (nRST),
        .rd_idx     (rd_idx),
        .rd_frames  (rd_frames),
        .wr_en      (wr_en),
        .wr_way     (wr_way),
        .wr_idx     (wr_idx),
        .wr_frame   (wr_frame),
        .lru_touch  (lru_touch),
        .lru_way    (lru_way),
        .lru_victim (lru_victim)
    );

    dcache_ctrl u_ctrl (
        .CLK        (CLK),
        .nRST       (nRST),
        .cpu_req    (cpu_req),
        .dhit       (dhit),
        .dmemload   (dmemload),
        .mem_req    (mem_req),
        .mem_wait   (mem_wait),
        .mem_load   (mem_load),
        .rd_idx     (rd_idx),
        .rd_frames  (rd_frames),
        .lru_victim (lru_victim),
        .wr_en      (wr_en),
        .wr_way     (wr_way),
        .wr_idx     (wr_idx),
        .wr_frame   (wr_frame),
        .lru_touch  (lru_touch),
        .lru_way    (lru_way),
        .events     (events),
        .flush_req  (flush_req),
        .flush_done (flush_done)
    );

    dcache_csr u_csr (
        .CLK        (CLK),
        .nRST       (nRST),
        .wb_req     (wb_req),
        .wb_rsp     (wb_rsp),
        .events     (events),
        .flush_done (flush_done),
        .flush_req  (flush_req)
    );

endmodule

`default_nettype wire

//--- dv/dcache_assertions.sv
`default_nettype none
`timescale 1ns/100ps

module dcache_assertions (
    input logic                 CLK,
    input logic                 nRST,
    input dcache_pkg::mem_req_t mem_req,
    input logic                 mem_wait,
    input dcache_pkg::wb_rsp_t  wb_rsp
);
    int unsigned fail_count = 0;

    // stalled memory request must not move
    a_mem_hold: assert property (@(posedge CLK) disable iff (!nRST)
        (mem_req.ren || mem_req.wen) && mem_wait |=> $stable(mem_req))
    else begin
        fail_count = fail_count + 1;
        $error("memory request changed while mem_wait was high");
    end

    a_mem_excl: assert property (@(posedge CLK) disable iff (!nRST)
        !(mem_req.ren && mem_req.wen))
    else begin
        fail_count = fail_count + 1;
        $error("memory ren and wen set together");
    end

    // single-cycle Wishbone ack
    a_ack_pulse: assert property (@(posedge CLK) disable iff (!nRST)
        wb_rsp.ack |=> !wb_rsp.ack)
    else begin
        fail_count = fail_count + 1;
        $error("Wishbone ack held longer than one cycle");
    end

endmodule

// top level sees both the memory and the Wishbone port
bind dcache_top dcache_assertions u_assertions (
    .CLK      (CLK),
    .nRST     (nRST),
    .mem_req  (mem_req),
    .mem_wait (mem_wait),
    .wb_rsp   (wb_rsp)
);

`default_nettype wire

//--- dv/dcache_tb.sv
`default_nettype none
`timescale 1ns/100ps

module dcache_tb;
    import dcache_pkg::*;

    localparam word_t SEED          = 32'h1f2c_a6e0;
    localparam int    NUM_OPS       = 200;
    localparam int    CYCLES_PER_OP = 20;
    localparam int    MAX_CYCLES    = NUM_OPS * CYCLES_PER_OP;

    // one completed memory access with zero data for reads
    typedef struct packed {
        logic  we;
        word_t addr;
        word_t data;
    } mem_op_t;

    logic     CLK;
    logic     nRST;
    cpu_req_t cpu_req;
    logic     dhit;
    word_t    dmemload;
    mem_req_t mem_req;
    logic     mem_wait;
    word_t    mem_load;
    wb_req_t  wb_req;
    wb_rsp_t  wb_rsp;

    word_t       cpu_rng;
    word_t       mem_rng;
    int          cycles;
    logic        mem_busy;
    logic [1:0]  wait_left;
    word_t       mem [word_t];
    word_t       ref_mem [word_t];
    mem_op_t     mem_log [$];
    mem_op_t     exp_log [$];

    // reference cache state
    logic              m_valid [DWAYS][DSETS];
    logic              m_dirty [DWAYS][DSETS];
    logic [DTAG_W-1:0] m_tag   [DWAYS][DSETS];
    logic              m_lru   [DSETS];
    int unsigned       m_hits;
    int unsigned       m_misses;
    int unsigned       m_wbacks;

    dcache_top UUT (
        .CLK      (CLK),
        .nRST     (nRST),
        .cpu_req  (cpu_req),
        .dhit     (dhit),
        .dmemload (dmemload),
        .mem_req  (mem_req),
        .mem_wait (mem_wait),
        .mem_load (mem_load),
        .wb_req   (wb_req),
        .wb_rsp   (wb_rsp)
    );

    initial begin
        CLK = 1'b0;
        forever #20 CLK = ~CLK;
    end

    function automatic word_t xorshift(input word_t x);
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic word_t rand_word();
        cpu_rng = xorshift(cpu_rng);
        return cpu_rng;
    endfunction

    // contents of a never written word
    function automatic word_t fill_word(input word_t addr);
        return {addr[15:0], addr[31:16]} ^ 32'h6b3d_91c5;
    endfunction

    function automatic word_t mem_read(input word_t addr);
        return mem.exists(addr) ? mem[addr] : fill_word(addr);
    endfunction

    function automatic word_t ref_read(input word_t addr);
        return ref_mem.exists(addr) ? ref_mem[addr] : fill_word(addr);
    endfunction

    function automatic word_t blk_addr(input logic [DTAG_W-1:0] tag,
                                       input logic [DIDX_W-1:0] idx,
                                       input logic              blk);
        return {tag, idx, blk, 2'b00};
    endfunction

    function automatic mem_op_t mem_op(input logic we, input word_t addr, input word_t data);
        mem_op_t op;
        op.we   = we;
        op.addr = addr;
        op.data = data;
        return op;
    endfunction

    // small tag pool so that sets conflict
    function automatic logic [DTAG_W-1:0] pick_tag(input logic [1:0] sel);
        case (sel)
            2'd0:    return 26'h000_0001;
            2'd1:    return 26'h000_0a5c;
            2'd2:    return 26'h012_3456;
            default: return 26'h3ff_fffe;
        endcase
    endfunction

    task automatic check(input string name, input logic [95:0] got, input logic [95:0] exp);
        if (got !== exp) begin
            $display("FAIL %0t %s got %0h expected %0h", $time, name, got, exp);
            $display("test failed");
            $fatal(1);
        end
    endtask

    // memory model picks a wait stretch when a request shows up
    always @(negedge CLK) begin
        if ((mem_req.ren || mem_req.wen) && !mem_busy) begin
            mem_busy  = 1'b1;
            mem_rng   = xorshift(mem_rng);
            wait_left = mem_rng[1:0];
        end
        if (mem_busy && wait_left != 0) begin
            mem_wait  = 1'b1;
            wait_left = wait_left - 1'b1;
        end else begin
            mem_wait = 1'b0;
        end
        mem_load = mem_req.ren ? mem_read(mem_req.addr) : '0;
    end

    always @(posedge CLK) begin
        if (nRST && mem_busy && (mem_req.ren || mem_req.wen) && !mem_wait) begin
            if (mem_req.wen) begin
                mem[mem_req.addr] = mem_req.store;
                mem_log.push_back(mem_op(1'b1, mem_req.addr, mem_req.store));
            end else begin
                mem_log.push_back(mem_op(1'b0, mem_req.addr, '0));
            end
            mem_busy = 1'b0;
        end
    end

    always @(posedge CLK) begin
        cycles = cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            $display("timeout: run did not finish within %0d cycles", MAX_CYCLES);
            $display("test failed");
            $fatal(1);
        end else if (UUT.u_assertions.fail_count != 0) begin
            $display("a handshake assertion failed at %0t", $time);
            $display("test failed");
            $fatal(1);
        end
    end

    task automatic wb_write(input logic [CSR_AW-1:0] adr, input word_t data);
        @(negedge CLK);
        wb_req.cyc   = 1'b1;
        wb_req.stb   = 1'b1;
        wb_req.we    = 1'b1;
        wb_req.adr   = adr;
        wb_req.dat_w = data;
        do @(posedge CLK); while (!wb_rsp.ack);
        @(negedge CLK);
        wb_req = '0;
    endtask

    task automatic wb_read(input logic [CSR_AW-1:0] adr, output word_t data);
        @(negedge CLK);
        wb_req.cyc   = 1'b1;
        wb_req.stb   = 1'b1;
        wb_req.we    = 1'b0;
        wb_req.adr   = adr;
        wb_req.dat_w = '0;
        do @(posedge CLK); while (!wb_rsp.ack);
        data = wb_rsp.dat_r;
        @(negedge CLK);
        wb_req = '0;
    endtask

    task automatic push_block_writes(input logic [DTAG_W-1:0] tag, input logic [DIDX_W-1:0] idx);
        word_t ad;
        for (int b = 0; b < 2; b++) begin
            ad = blk_addr(tag, idx, b[0]);
            exp_log.push_back(mem_op(1'b1, ad, ref_read(ad)));
        end
    endtask

    task automatic compare_log();
        check("memory access count", mem_log.size(), exp_log.size());
        foreach (exp_log[i]) begin
            check($sformatf("memory access %0d", i), mem_log[i], exp_log[i]);
        end
    endtask

    task automatic run_op();
        word_t        r;
        word_t        store;
        word_t        key;
        word_t        exp_data;
        word_t        got;
        dcache_addr_t a;
        logic         is_wr;
        logic         way;
        logic [1:0]   hit_vec;
        int           edges;

        r        = rand_word();
        store    = rand_word();
        is_wr    = r[0];
        a.tag    = pick_tag(r[2:1]);
        a.idx    = r[5:3];
        a.blkoff = r[6];
        a.bytoff = '0;
        key      = word_t'(a);
        for (int w = 0; w < DWAYS; w++) begin
            hit_vec[w] = m_valid[w][a.idx] && (m_tag[w][a.idx] == a.tag);
        end

        // predicted memory traffic
        exp_log.delete();
        mem_log.delete();
        if (hit_vec != 2'b00) begin
            way    = hit_vec[1];
            m_hits = m_hits + 1;
        end else begin
            m_misses = m_misses + 1;
            way      = m_lru[a.idx];
            if (m_dirty[way][a.idx]) begin
                push_block_writes(m_tag[way][a.idx], a.idx);
                m_wbacks = m_wbacks + 1;
            end
            exp_log.push_back(mem_op(1'b0, blk_addr(a.tag, a.idx, 1'b0), '0));
            exp_log.push_back(mem_op(1'b0, blk_addr(a.tag, a.idx, 1'b1), '0));
            m_valid[way][a.idx] = 1'b1;
            m_dirty[way][a.idx] = 1'b0;
            m_tag[way][a.idx]   = a.tag;
        end
        exp_data = is_wr ? store : ref_read(key);

        @(negedge CLK);
        cpu_req.ren   = !is_wr;
        cpu_req.wen   = is_wr;
        cpu_req.addr  = a;
        cpu_req.store = store;
        edges         = 0;
        do begin
            @(posedge CLK);
            edges = edges + 1;
        end while (!dhit);
        got = dmemload;
        @(negedge CLK);
        cpu_req = '0;

        check("dmemload", got, exp_data);
        // a hit answers at the first edge
        if (hit_vec != 2'b00) begin
            check("dhit latency", edges, 1);
        end
        compare_log();
        m_lru[a.idx] = ~way;
        if (is_wr) begin
            m_dirty[way][a.idx] = 1'b1;
            ref_mem[key]        = store;
        end
    endtask

    task automatic check_counters();
        word_t v;
        wb_read(CSR_HITS, v);
        check("HITS", v, m_hits);
        wb_read(CSR_MISSES, v);
        check("MISSES", v, m_misses);
        wb_read(CSR_WBACKS, v);
        check("WBACKS", v, m_wbacks);
        wb_read(5'h14, v);
        check("unmapped register", v, 32'h0);
    endtask

    task automatic clear_counters();
        wb_write(CSR_CTRL, 32'h2);
        m_hits   = 0;
        m_misses = 0;
        m_wbacks = 0;
        check_counters();
    endtask

    task automatic flush_and_check();
        word_t st;
        int    blocks;
        blocks = 0;
        exp_log.delete();
        // way 0 before way 1 and each in index order
        for (int w = 0; w < DWAYS; w++) begin
            for (int i = 0; i < DSETS; i++) begin
                if (m_dirty[w][i]) begin
                    push_block_writes(m_tag[w][i], DIDX_W'(i));
                    blocks = blocks + 1;
                end
            end
        end
        mem_log.delete();
        wb_write(CSR_CTRL, 32'h1);
        do wb_read(CSR_STATUS, st); while (!st[0]);
        check("STATUS", st, 32'h1);
        compare_log();
        // with nothing dirty left, memory holds every word last written
        foreach (ref_mem[ad]) begin
            check($sformatf("memory word %h", ad), mem_read(ad), ref_mem[ad]);
        end
        for (int w = 0; w < DWAYS; w++) begin
            for (int i = 0; i < DSETS; i++) begin
                m_dirty[w][i] = 1'b0;
            end
        end
        m_wbacks = m_wbacks + blocks;
    endtask

    initial begin
        nRST      = 1'b0;
        cpu_req   = '0;
        wb_req    = '0;
        mem_wait  = 1'b0;
        mem_load  = '0;
        cpu_rng   = SEED;
        mem_rng   = ~SEED;
        cycles    = 0;
        mem_busy  = 1'b0;
        wait_left = '0;
        m_hits    = 0;
        m_misses  = 0;
        m_wbacks  = 0;
        for (int i = 0; i < DSETS; i++) begin
            m_lru[i] = 1'b0;
            for (int w = 0; w < DWAYS; w++) begin
                m_valid[w][i] = 1'b0;
                m_dirty[w][i] = 1'b0;
                m_tag[w][i]   = '0;
            end
        end

        repeat (3) @(posedge CLK);
        @(negedge CLK);
        nRST = 1'b1;
        check_counters();

        repeat (80) run_op();
        check_counters();
        flush_and_check();
        check_counters();

        // cleaned blocks must not be written back again after a flush
        repeat (80) run_op();
        check_counters();
        clear_counters();
        repeat (40) run_op();
        check_counters();
        flush_and_check();
        check_counters();

        if (UUT.u_assertions.fail_count == 0) begin
            $display("test passed");
            $finish;
        end else begin
            $display("test failed");
            $fatal(1);
        end
    end

endmodule

`default_nettype wire

//--- dcache_top.f
hdl/dcache_pkg.sv
hdl/dcache_frames.sv
hdl/dcache_ctrl.sv
hdl/dcache_csr.sv
hdl/dcache_top.sv
dv/dcache_assertions.sv
dv/dcache_tb.sv
